//--- src/cpuIdPkg.sv
`default_nettype none

package cpuIdPkg;

	// result and query widths
	localparam int wordWidth = 64;
	localparam int indexWidth = 5;

	// timer ticks reported in the feature word
	localparam int tickWidth = 4;

	// build-time feature mask, one bit per optional core unit
	localparam int featureWidth = 16;

	// reserved gaps around the feature and tick fields of the index-1 word
	localparam int featureLow = 8;
	localparam int midGapWidth = featureLow - tickWidth;
	localparam int topGapWidth = wordWidth - featureWidth - featureLow;

	// query index codes
	localparam logic [indexWidth-1:0] idxSignature = 5'd0;
	localparam logic [indexWidth-1:0] idxFeatures = 5'd1;
	localparam logic [indexWidth-1:0] idxRandom = 5'd31;

	// "BJX2F0  " packed little-endian, first character in the low byte
	localparam logic [wordWidth-1:0] signatureWord = {
		8'h20,
		8'h20,
		8'h30,
		8'h46,
		8'h32,
		8'h58,
		8'h4A,
		8'h42
	};

	// field layout of the index-1 word, top bit first
	typedef struct packed {
		logic [topGapWidth-1:0] reservedHi;
		logic [featureWidth-1:0] features;
		logic [midGapWidth-1:0] reservedLo;
		logic [tickWidth-1:0] tickCount;
	} featureFieldsT;

	// same 64 bits seen either as a plain word or as fields
	typedef union packed {
		logic [wordWidth-1:0] raw;
		featureFieldsT fields;
	} featureWordT;

	// generators of the entropy source are half a result word each
	localparam int genWidth = wordWidth / 2;

	// reset seeds, distinct and nonzero
	localparam logic [genWidth-1:0] seedA = 32'h1357_9BDF;
	localparam logic [genWidth-1:0] seedB = 32'h2468_ACE1;

	// nibble used by the output interleave
	localparam int nibbleWidth = 4;
	localparam int nibbleCount = genWidth / nibbleWidth;

endpackage

`default_nettype wire

//--- src/cycleTimer.sv
`timescale 1ns/10ps
`default_nettype none

module cycleTimer #(
	parameter int tickDivider = 16
) (
	input logic clock,
	input logic rst,
	output logic [cpuIdPkg::tickWidth-1:0] tickCount,
	output logic noiseBit
);

	// a divider of one still needs a one-bit prescaler
	localparam int prescWidth = (tickDivider > 1) ? $clog2(tickDivider) : 1;
	localparam logic [prescWidth-1:0] prescLast = prescWidth'(tickDivider - 1);

	logic [prescWidth-1:0] prescaler;
	logic prescWrap;

	// last prescaler state before it returns to zero
	assign prescWrap = (prescaler == prescLast);

	// prescaler counts 0 .. tickDivider-1
	always_ff @(posedge clock) begin
		if (rst) begin
			prescaler <= '0;
		end else if (prescWrap) begin
			prescaler <= '0;
		end else begin
			prescaler <= prescaler + 1'b1;
		end
	end

	// tick advances once per prescaler wrap, wraps modulo 16
	always_ff @(posedge clock) begin
		if (rst) begin
			tickCount <= '0;
		end else if (prescWrap) begin
			tickCount <= tickCount + 1'b1;
		end
	end

	// fast-toggling bit for the entropy source
	// holds over the wrap when the divider is odd
	assign noiseBit = prescaler[0];

endmodule

`default_nettype wire

//--- src/entropySource.sv
`timescale 1ns/10ps
`default_nettype none

module entropySource (
	input logic clock,
	input logic rst,
	input logic noiseBit,
	output logic [cpuIdPkg::wordWidth-1:0] randomWord
);

	localparam int genWidth = cpuIdPkg::genWidth;
	localparam int nibbleWidth = cpuIdPkg::nibbleWidth;
	localparam int nibbleCount = cpuIdPkg::nibbleCount;

	// the two generators
	logic [genWidth-1:0] rngA;
	logic [genWidth-1:0] rngB;

	// new top bits this cycle and last cycle
	logic fbA;
	logic fbB;
	logic fbALast;
	logic fbBLast;

	// noise synchronizer
	logic noiseSync1;
	logic noiseSync2;
	logic noiseMix;

	// timer bit comes from another always block, two stages before use
	always_ff @(posedge clock) begin
		if (rst) begin
			noiseSync1 <= 1'b0;
			noiseSync2 <= 1'b0;
		end else begin
			noiseSync1 <= noiseBit;
			noiseSync2 <= noiseSync1;
		end
	end

	// high whenever the noise bit changed between the two stages
	assign noiseMix = noiseSync1 ^ noiseSync2;

	// odd taps, noise, the other generator's last bit, and a forced one
	assign fbA = rngA[1] ^ rngA[3] ^ rngA[5] ^ rngA[7] ^ noiseMix ^ fbBLast ^ 1'b1;
	assign fbB = rngB[1] ^ rngB[3] ^ rngB[5] ^ rngB[7] ^ noiseMix ^ fbALast ^ 1'b1;

	// shift right every cycle, new bit enters at the top
	always_ff @(posedge clock) begin
		if (rst) begin
			rngA <= cpuIdPkg::seedA;
			rngB <= cpuIdPkg::seedB;
			fbALast <= 1'b0;
			fbBLast <= 1'b0;
		end else begin
			rngA <= {fbA, rngA[genWidth-1:1]};
			rngB <= {fbB, rngB[genWidth-1:1]};
			fbALast <= fbA;
			fbBLast <= fbB;
		end
	end

	// A walks down from its high nibble, B walks up from its low nibble
	always_comb begin
		for (int i = 0; i < nibbleCount; i++) begin
			randomWord[cpuIdPkg::wordWidth - 1 - 2*nibbleWidth*i -: nibbleWidth] =
				rngA[genWidth - 1 - nibbleWidth*i -: nibbleWidth];
			randomWord[cpuIdPkg::wordWidth - 1 - nibbleWidth - 2*nibbleWidth*i -: nibbleWidth] =
				rngB[nibbleWidth*i +: nibbleWidth];
		end
	end

endmodule

`default_nettype wire

//--- src/cpuIdDecode.sv
`timescale 1ns/10ps
`default_nettype none

module cpuIdDecode #(
	parameter logic [cpuIdPkg::featureWidth-1:0] featureMask = '0
) (
	input logic clock,
	input logic rst,
	input logic [cpuIdPkg::indexWidth-1:0] index,
	input logic [cpuIdPkg::tickWidth-1:0] tickCount,
	input logic [cpuIdPkg::wordWidth-1:0] randomWord,
	output logic [cpuIdPkg::wordWidth-1:0] resLo,
	output logic [cpuIdPkg::wordWidth-1:0] resHi
);

	// index-1 answer
	cpuIdPkg::featureWordT featureWord;

	// selected low word before the result register
	logic [cpuIdPkg::wordWidth-1:0] nextLo;

	// per-index hit flags
	logic hitSignature;
	logic hitFeatures;
	logic hitRandom;

	// feature word: mask in the middle, live tick count at the bottom
	always_comb begin
		featureWord.fields.reservedHi = '0;
		featureWord.fields.features = featureMask;
		featureWord.fields.reservedLo = '0;
		featureWord.fields.tickCount = tickCount;
	end

	assign hitSignature = (index == cpuIdPkg::idxSignature);
	assign hitFeatures = (index == cpuIdPkg::idxFeatures);
	assign hitRandom = (index == cpuIdPkg::idxRandom);

	// low word select, every unused index reads zero
	always_comb begin
		nextLo = '0;
		if (hitSignature) begin
			nextLo = cpuIdPkg::signatureWord;
		end else if (hitFeatures) begin
			nextLo = featureWord.raw;
		end else if (hitRandom) begin
			nextLo = randomWord;
		end
	end

	// one register stage from index to results
	// high word has no defined contents yet
	// the core reads the pair as one register couple
	always_ff @(posedge clock) begin
		if (rst) begin
			resLo <= '0;
			resHi <= '0;
		end else begin
			resLo <= nextLo;
			resHi <= '0;
		end
	end

endmodule

`default_nettype wire

//--- src/cpuIdUnit.sv
`timescale 1ns/10ps
`default_nettype none

module cpuIdUnit #(
	parameter logic [cpuIdPkg::featureWidth-1:0] featureMask = '0,
	parameter int tickDivider = 16
) (
	input logic clock,
	input logic rst,
	input logic [cpuIdPkg::indexWidth-1:0] index,
	output logic [cpuIdPkg::wordWidth-1:0] resLo,
	output logic [cpuIdPkg::wordWidth-1:0] resHi
);

	logic [cpuIdPkg::tickWidth-1:0] tickCount;
	logic noiseBit;
	logic [cpuIdPkg::wordWidth-1:0] randomWord;

	// stand-in for the core timer block
	cycleTimer #(
		.tickDivider(tickDivider)
	) timer (
		.clock(clock),
		.rst(rst),
		.tickCount(tickCount),
		.noiseBit(noiseBit)
	);

	entropySource entropy (
		.clock(clock),
		.rst(rst),
		.noiseBit(noiseBit),
		.randomWord(randomWord)
	);

	cpuIdDecode #(
		.featureMask(featureMask)
	) decode (
		.clock(clock),
		.rst(rst),
		.index(index),
		.tickCount(tickCount),
		.randomWord(randomWord),
		.resLo(resLo),
		.resHi(resHi)
	);

endmodule

`default_nettype wire

//--- tb/clockGen.sv
`timescale 1ns/10ps
`default_nettype none

module clockGen #(
	parameter int periodNs = 100
) (
	output logic clock
);

	localparam int halfPeriod = periodNs / 2;

	// free-running, starts low so the first rising edge is at half a period
	initial begin
		clock = 1'b0;
		forever begin
			#(halfPeriod) clock = ~clock;
		end
	end

endmodule

`default_nettype wire

//--- tb/cpuIdUnit_props.sv
`timescale 1ns/10ps
`default_nettype none

module cpuIdUnitProps (
	input logic clock,
	input logic rst,
	input logic [cpuIdPkg::indexWidth-1:0] index,
	input logic [cpuIdPkg::wordWidth-1:0] resLo,
	input logic [cpuIdPkg::wordWidth-1:0] resHi
);

	// a reset cycle leaves both result words cleared
	resetClears: assert property (
		@(posedge clock) rst |=> (resLo == '0 && resHi == '0)
	) else $error("result pair not cleared after a reset cycle");

	// upper word carries nothing yet
	hiAlwaysZero: assert property (
		@(posedge clock) disable iff (rst) resHi == '0
	) else $error("resHi nonzero outside reset");

	// signature appears one edge after a query taken outside reset
	signatureNext: assert property (
		@(posedge clock) disable iff (rst)
		(!rst && index == cpuIdPkg::idxSignature) |=> (resLo == cpuIdPkg::signatureWord)
	) else $error("index 0 query did not return the signature word");

endmodule

`default_nettype wire

//--- tb/cpuIdUnitTb.sv
`timescale 1ns/10ps
`default_nettype none

module cpuIdUnitTb;

	localparam logic [15:0] featureMask = 16'hA5C3;
	localparam int tickDivider = 16;
	// tests need well under 200 cycles
	localparam int cycleLimit = 2000;

	logic clock;
	logic rst;
	logic [4:0] index;
	logic [63:0] resLo;
	logic [63:0] resHi;

	// edges seen with rst low, and total edges for the timeout
	int liveEdges;
	int cycleCount;

	clockGen #(.periodNs(100)) clkGen (.clock(clock));

	cpuIdUnit #(
		.featureMask(featureMask),
		.tickDivider(tickDivider)
	) uut (
		.clock(clock),
		.rst(rst),
		.index(index),
		.resLo(resLo),
		.resHi(resHi)
	);

	bind cpuIdUnit cpuIdUnitProps props (
		.clock(clock),
		.rst(rst),
		.index(index),
		.resLo(resLo),
		.resHi(resHi)
	);

	task automatic endWithFailure();
		$display("tests failed");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic reportValue(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
		endWithFailure();
	endtask

	task automatic reportProblem(input string reason);
		$display("%s", reason);
		endWithFailure();
	endtask

	always @(posedge clock) begin
		if (rst) begin
			liveEdges <= 0;
		end else begin
			liveEdges <= liveEdges + 1;
		end
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			reportProblem($sformatf("simulation ran past the limit of %0d cycles", cycleLimit));
		end
	end

	// eight characters, first one in the low byte
	function automatic logic [63:0] packText(input string text);
		logic [63:0] word;
		word = '0;
		for (int i = 0; i < 8; i++) begin
			word[8*i +: 8] = text[i];
		end
		return word;
	endfunction

	// tick count captured at the e-th edge after reset
	function automatic logic [3:0] expectedTick(input int edges);
		return 4'(((edges - 1) / tickDivider) % 16);
	endfunction

	task automatic compareWord(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		assert (actual === expected) else begin
			reportValue(name, expected, actual);
		end
	endtask

	task automatic verifyFeatureFields(input logic [63:0] lo, input logic [3:0] tick);
		cpuIdPkg::featureWordT decoded;
		decoded.raw = lo;
		compareWord("resLo.features", 64'(featureMask), 64'(decoded.fields.features));
		compareWord("resLo.reservedHi", '0, 64'(decoded.fields.reservedHi));
		compareWord("resLo.reservedLo", '0, 64'(decoded.fields.reservedLo));
		compareWord("resLo.tickCount", 64'(tick), 64'(decoded.fields.tickCount));
	endtask

	// drive at the rising edge, sample at the falling edge
	// the sample belongs to the index of the previous call
	task automatic stepCycle(input logic [4:0] idx, output logic [63:0] lo,
			output logic [63:0] hi);
		@(posedge clock);
		index <= idx;
		@(negedge clock);
		lo = resLo;
		hi = resHi;
	endtask

	task automatic queryIndex(input logic [4:0] idx, output logic [63:0] lo,
			output logic [63:0] hi);
		stepCycle(idx, lo, hi);
		stepCycle(idx, lo, hi);
	endtask

	task automatic verifyAnswer(input logic [4:0] asked, input logic [63:0] lo,
			input logic [63:0] hi);
		compareWord($sformatf("resHi (index %0d)", asked), '0, hi);
		if (asked == 5'd0) begin
			compareWord("resLo (index 0)", packText("BJX2F0  "), lo);
		end else if (asked == 5'd1) begin
			verifyFeatureFields(lo, expectedTick(liveEdges));
		end else if (asked == 5'd31) begin
			assert (lo != '0) else begin
				reportProblem("index 31 returned an all-zero random word");
			end
		end else begin
			compareWord($sformatf("resLo (index %0d)", asked), '0, lo);
		end
	endtask

	task automatic resetClearsResults();
		for (int i = 0; i < 8; i++) begin
			@(posedge clock);
			if (i == 7) begin
				rst <= 1'b0;
			end
			@(negedge clock);
			compareWord("resLo (reset)", '0, resLo);
			compareWord("resHi (reset)", '0, resHi);
		end
	endtask

	task automatic readSignature();
		logic [63:0] lo;
		logic [63:0] hi;
		queryIndex(5'd0, lo, hi);
		verifyAnswer(5'd0, lo, hi);
	endtask

	task automatic sweepUnusedIndices();
		int order [29];
		int j;
		int tmp;
		logic [63:0] lo;
		logic [63:0] hi;
		for (int k = 0; k < 29; k++) begin
			order[k] = k + 2;
		end
		for (int k = 28; k > 0; k--) begin
			j = int'($urandom_range(k, 0));
			tmp = order[k];
			order[k] = order[j];
			order[j] = tmp;
		end
		for (int k = 0; k < 29; k++) begin
			queryIndex(5'(order[k]), lo, hi);
			verifyAnswer(5'(order[k]), lo, hi);
		end
	endtask

	task automatic readFeatureWord();
		logic [63:0] lo;
		logic [63:0] hi;
		logic [3:0] firstTick;
		queryIndex(5'd1, lo, hi);
		firstTick = expectedTick(liveEdges);
		verifyAnswer(5'd1, lo, hi);
		// three full prescaler periods later
		repeat (3 * tickDivider) begin
			stepCycle(5'd1, lo, hi);
		end
		compareWord("resHi (index 1)", '0, hi);
		verifyFeatureFields(lo, firstTick + 4'd3);
	endtask

	task automatic sampleRandomWords();
		logic [63:0] words [16];
		logic [63:0] hi;
		stepCycle(5'd31, words[0], hi);
		for (int i = 0; i < 16; i++) begin
			stepCycle(5'd31, words[i], hi);
			verifyAnswer(5'd31, words[i], hi);
		end
		for (int a = 0; a < 15; a++) begin
			for (int b = a + 1; b < 16; b++) begin
				assert (words[a] != words[b]) else begin
					reportProblem($sformatf("random reads %0d and %0d both gave %h",
						a, b, words[a]));
				end
			end
		end
	endtask

	task automatic runBackToBack();
		logic [4:0] indexOrder [7];
		logic [63:0] lo;
		logic [63:0] hi;
		indexOrder = '{5'd0, 5'd1, 5'd5, 5'd0, 5'd31, 5'd2, 5'd0};
		stepCycle(indexOrder[0], lo, hi);
		for (int i = 1; i <= 7; i++) begin
			stepCycle((i < 7) ? indexOrder[i] : 5'd0, lo, hi);
			verifyAnswer(indexOrder[i-1], lo, hi);
		end
	endtask

	initial begin
		rst = 1'b1;
		index = '0;
		void'($urandom(32'h0dde_c137));
		resetClearsResults();
		readSignature();
		sweepUnusedIndices();
		readFeatureWord();
		sampleRandomWords();
		runBackToBack();
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
src/cpuIdPkg.sv
src/cycleTimer.sv
src/entropySource.sv
src/cpuIdDecode.sv
src/cpuIdUnit.sv
tb/clockGen.sv
tb/cpuIdUnit_props.sv
tb/cpuIdUnitTb.sv

//--- run.sh
#!/bin/sh
# build and run the cpuIdUnit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module cpuIdUnitTb -f project.f -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
	echo "simulation exited with status $runStatus"
	exit 1
fi

if grep -q "^all tests passed$" sim.log; then
	exit 0
else
	echo "pass message not found in sim.log"
	exit 1
fi
